/* verilog/cart_pkg.sv */
// Shared constants and vector types for the sound cartridge model.
// Holds the I/O port map, PSG register indices and timing constants.
// Other files refer to these by scoped names.

package cart_pkg;

	// Bus and sound vector types
	typedef logic [7:0] io_addr_t;
	typedef logic [7:0] bus_data_t;
	// Unsigned mix level, also used as PWM duty
	typedef logic [7:0] mix_level_t;

	// --------------------------------------------------------------------
	// I/O port map
	// --------------------------------------------------------------------
	localparam io_addr_t PORT_PSG_ADDR     = 8'hA0;
	localparam io_addr_t PORT_PSG_WRITE    = 8'hA1;
	localparam io_addr_t PORT_PSG_READ     = 8'hA2;
	localparam io_addr_t PORT_TIMER_RELOAD = 8'hA4;
	localparam io_addr_t PORT_TIMER_CTRL   = 8'hA5;

	// --------------------------------------------------------------------
	// PSG register indices
	// --------------------------------------------------------------------
	localparam logic [3:0] REG_PERIOD_A = 4'd0;
	localparam logic [3:0] REG_PERIOD_B = 4'd1;
	localparam logic [3:0] REG_PERIOD_C = 4'd2;
	localparam logic [3:0] REG_ENABLE   = 4'd7;
	localparam logic [3:0] REG_VOLUME_A = 4'd8;
	localparam logic [3:0] REG_VOLUME_B = 4'd9;
	localparam logic [3:0] REG_VOLUME_C = 4'd10;

	// Timing
	localparam int MCLK_DIV            = 6;
	localparam int STARTUP_WAIT_CYCLES = 16;
	localparam int PWM_PERIOD          = 256;
	localparam int VOLUME_SHIFT        = 2;

endpackage

/* verilog/cart_io_bus_if.sv */
// Internal I/O bus between the cartridge top level and its peripherals.
// The top level drives every signal; peripherals only listen.

`timescale 1ns/1ps

interface cart_io_bus_if;

	// CPU strobes, active low
	logic                 n_iorq;
	logic                 n_rd;
	logic                 n_wr;
	// Low byte of the I/O address and write data
	cart_pkg::io_addr_t   address;
	cart_pkg::bus_data_t  wdata;
	// One clk pulse at the start of an I/O write
	logic                 wr_strobe;

	modport master (
		output n_iorq, n_rd, n_wr, address, wdata, wr_strobe
	);

	modport peripheral (
		input n_iorq, n_rd, n_wr, address, wdata, wr_strobe
	);

endinterface

/* verilog/cart_timing.sv */
// Master-clock enable and startup wait for the cartridge.
// mclk_en pulses once every MCLK_DIV clk; twait holds the CPU
// for STARTUP_WAIT_CYCLES clk after reset is released.

`timescale 1ns/1ps

module cart_timing (
	input  logic clk,
	input  logic w_n_reset,
	output logic mclk_en,
	output logic twait
);

	logic [2:0] div_cnt;
	logic [4:0] wait_cnt;

	// --------------------------------------------------------------------
	// Divide by six
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			div_cnt <= 3'd0;
			mclk_en <= 1'b0;
		end else begin
			// Pulse as the counter wraps back to zero
			mclk_en <= (div_cnt == 3'(cart_pkg::MCLK_DIV - 1));
			if (div_cnt == 3'(cart_pkg::MCLK_DIV - 1)) begin
				div_cnt <= 3'd0;
			end else begin
				div_cnt <= div_cnt + 3'd1;
			end
		end
	end

	// --------------------------------------------------------------------
	// Startup wait
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			wait_cnt <= 5'd0;
		end else if (wait_cnt != 5'(cart_pkg::STARTUP_WAIT_CYCLES)) begin
			wait_cnt <= wait_cnt + 5'd1;
		end
	end

	// Stays low once the count saturates
	assign twait = (wait_cnt != 5'(cart_pkg::STARTUP_WAIT_CYCLES));

endmodule

/* verilog/psg_regs.sv */
// PSG register block on the I/O bus.
// Port A0h latches the register index, A1h writes the indexed register,
// A2h reads it back. Outputs feed the tone generator directly.

`timescale 1ns/1ps

module psg_regs (
	input  logic                 clk,
	input  logic                 w_n_reset,
	cart_io_bus_if.peripheral    bus,
	output cart_pkg::bus_data_t  rdata,
	output logic                 rdata_en,
	output cart_pkg::bus_data_t  period_a,
	output cart_pkg::bus_data_t  period_b,
	output cart_pkg::bus_data_t  period_c,
	output logic [2:0]           tone_enable_n,
	output logic [3:0]           volume_a,
	output logic [3:0]           volume_b,
	output logic [3:0]           volume_c
);

	logic [3:0]          reg_index;
	cart_pkg::bus_data_t enable_reg;
	cart_pkg::bus_data_t read_value;
	logic                rd_match;

	// Low bit of enable register gates channel A
	assign tone_enable_n = enable_reg[2:0];

	// --------------------------------------------------------------------
	// Index latch and register writes
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			reg_index  <= 4'd0;
			period_a   <= '0;
			period_b   <= '0;
			period_c   <= '0;
			// All tones off
			enable_reg <= 8'hFF;
			volume_a   <= 4'd0;
			volume_b   <= 4'd0;
			volume_c   <= 4'd0;
		end else if (bus.wr_strobe) begin
			if (bus.address == cart_pkg::PORT_PSG_ADDR) begin
				reg_index <= bus.wdata[3:0];
			end else if (bus.address == cart_pkg::PORT_PSG_WRITE) begin
				case (reg_index)
					cart_pkg::REG_PERIOD_A: period_a   <= bus.wdata;
					cart_pkg::REG_PERIOD_B: period_b   <= bus.wdata;
					cart_pkg::REG_PERIOD_C: period_c   <= bus.wdata;
					cart_pkg::REG_ENABLE:   enable_reg <= bus.wdata;
					cart_pkg::REG_VOLUME_A: volume_a   <= bus.wdata[3:0];
					cart_pkg::REG_VOLUME_B: volume_b   <= bus.wdata[3:0];
					cart_pkg::REG_VOLUME_C: volume_c   <= bus.wdata[3:0];
					// Writes to unused indices are dropped
					default: ;
				endcase
			end
		end
	end

	// --------------------------------------------------------------------
	// Read-back
	// --------------------------------------------------------------------
	always_comb begin
		case (reg_index)
			cart_pkg::REG_PERIOD_A: read_value = period_a;
			cart_pkg::REG_PERIOD_B: read_value = period_b;
			cart_pkg::REG_PERIOD_C: read_value = period_c;
			cart_pkg::REG_ENABLE:   read_value = enable_reg;
			cart_pkg::REG_VOLUME_A: read_value = {4'h0, volume_a};
			cart_pkg::REG_VOLUME_B: read_value = {4'h0, volume_b};
			cart_pkg::REG_VOLUME_C: read_value = {4'h0, volume_c};
			default:                read_value = 8'hFF;
		endcase
	end

	assign rd_match = !bus.n_iorq && !bus.n_rd &&
		(bus.address == cart_pkg::PORT_PSG_READ);

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			rdata_en <= 1'b0;
		end else begin
			rdata_en <= rd_match;
		end
	end

	// Data follows the enable, only seen while rdata_en is high
	always_ff @(posedge clk) begin
		rdata <= read_value;
	end

endmodule

/* verilog/psg_tone.sv */
// Three square-wave tone channels clocked by mclk_en.
// Audible channels add their scaled volume into one registered mix level.

`timescale 1ns/1ps

module psg_tone (
	input  logic                  clk,
	input  logic                  w_n_reset,
	input  logic                  mclk_en,
	input  cart_pkg::bus_data_t   period_a,
	input  cart_pkg::bus_data_t   period_b,
	input  cart_pkg::bus_data_t   period_c,
	input  logic [2:0]            tone_enable_n,
	input  logic [3:0]            volume_a,
	input  logic [3:0]            volume_b,
	input  logic [3:0]            volume_c,
	output cart_pkg::mix_level_t  mix_level
);

	cart_pkg::bus_data_t  period [3];
	logic [3:0]           volume [3];
	logic [7:0]           tone_cnt [3];
	logic [2:0]           wave;
	cart_pkg::mix_level_t mix_next;

	// Channel order A, B, C
	assign period[0] = period_a;
	assign period[1] = period_b;
	assign period[2] = period_c;
	assign volume[0] = volume_a;
	assign volume[1] = volume_b;
	assign volume[2] = volume_c;

	// --------------------------------------------------------------------
	// Tone counters
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			for (int i = 0; i < 3; i++) begin
				tone_cnt[i] <= 8'd0;
				wave[i]     <= 1'b0;
			end
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (period[i] == 8'd0) begin
					// Zero period parks the wave high
					tone_cnt[i] <= 8'd0;
					wave[i]     <= 1'b1;
				end else if (mclk_en) begin
					if (tone_cnt[i] >= period[i] - 8'd1) begin
						tone_cnt[i] <= 8'd0;
						wave[i]     <= ~wave[i];
					end else begin
						tone_cnt[i] <= tone_cnt[i] + 8'd1;
					end
				end
			end
		end
	end

	// --------------------------------------------------------------------
	// Mixer
	// --------------------------------------------------------------------
	always_comb begin
		mix_next = '0;
		for (int i = 0; i < 3; i++) begin
			// Max 3 * 15 * 4 = 180, fits in 8 bits
			if (!tone_enable_n[i] && wave[i]) begin
				mix_next = mix_next +
					(cart_pkg::mix_level_t'(volume[i]) << cart_pkg::VOLUME_SHIFT);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			mix_level <= '0;
		end else begin
			mix_level <= mix_next;
		end
	end

endmodule

/* verilog/cart_timer_irq.sv */
// Repeating down-counter timer standing in for the FM timer interrupt.
// A4h sets the reload value, A5h controls run, interrupt enable and flag clear.

`timescale 1ns/1ps

module cart_timer_irq (
	input  logic                 clk,
	input  logic                 w_n_reset,
	input  logic                 mclk_en,
	cart_io_bus_if.peripheral    bus,
	output cart_pkg::bus_data_t  rdata,
	output logic                 rdata_en,
	output logic                 tint
);

	cart_pkg::bus_data_t reload;
	cart_pkg::bus_data_t count;
	logic                run;
	logic                irq_en;
	logic                flag;
	logic                rd_match;

	// --------------------------------------------------------------------
	// Control writes and counter
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			reload <= '0;
			count  <= '0;
			run    <= 1'b0;
			irq_en <= 1'b0;
			flag   <= 1'b0;
		end else begin
			if (bus.wr_strobe && bus.address == cart_pkg::PORT_TIMER_RELOAD) begin
				reload <= bus.wdata;
			end
			if (bus.wr_strobe && bus.address == cart_pkg::PORT_TIMER_CTRL) begin
				run    <= bus.wdata[0];
				irq_en <= bus.wdata[1];
				if (bus.wdata[7]) begin
					flag <= 1'b0;
				end
			end
			// Stopped timer tracks the reload value
			if (!run) begin
				count <= reload;
			end else if (mclk_en) begin
				if (count == 8'd0) begin
					// Expiry wins over a same-cycle clear
					flag  <= 1'b1;
					count <= reload;
				end else begin
					count <= count - 8'd1;
				end
			end
		end
	end

	// Interrupt pin, one clk behind the flag
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			tint <= 1'b0;
		end else begin
			tint <= flag & irq_en;
		end
	end

	// --------------------------------------------------------------------
	// Status read
	// --------------------------------------------------------------------
	assign rd_match = !bus.n_iorq && !bus.n_rd &&
		(bus.address == cart_pkg::PORT_TIMER_CTRL);

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			rdata_en <= 1'b0;
		end else begin
			rdata_en <= rd_match;
		end
	end

	always_ff @(posedge clk) begin
		rdata <= {6'd0, run, flag};
	end

endmodule

/* verilog/sound_pwm.sv */
// One-bit PWM sound output.
// The duty is taken from mix_level once per frame, so every frame
// carries a single level.

`timescale 1ns/1ps

module sound_pwm (
	input  logic                  clk,
	input  logic                  w_n_reset,
	input  cart_pkg::mix_level_t  mix_level,
	output logic                  tsnd
);

	logic [7:0]           frame_cnt;
	cart_pkg::mix_level_t duty;

	// --------------------------------------------------------------------
	// Frame counter and duty latch
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			frame_cnt <= 8'd0;
			duty      <= '0;
		end else begin
			// Wraps every PWM_PERIOD clk
			frame_cnt <= frame_cnt + 8'd1;
			if (frame_cnt == 8'(cart_pkg::PWM_PERIOD - 1)) begin
				duty <= mix_level;
			end
		end
	end

	// High for the first duty cycles of each frame
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			tsnd <= 1'b0;
		end else begin
			tsnd <= (frame_cnt < duty);
		end
	end

endmodule

/* verilog/tangcart_top.sv */
// Cartridge top level for the MSX sound and interrupt model.
// Maps the CPU I/O pins onto the internal bus, joins the PSG, timer,
// clock timing and PWM blocks, and returns read data on td_out.

`timescale 1ns/1ps

module tangcart_top (
	input  logic                 clk,
	input  logic                 w_n_reset,
	input  logic                 n_tiorq,
	input  logic                 n_trd,
	input  logic                 n_twr,
	input  cart_pkg::io_addr_t   ta,
	input  cart_pkg::bus_data_t  td_in,
	output cart_pkg::bus_data_t  td_out,
	output logic                 tdir,
	output logic                 twait,
	output logic                 tint,
	output logic                 tsnd
);

	cart_io_bus_if bus ();

	logic                 mclk_en;
	logic                 wr_cond;
	logic                 wr_cond_q;
	cart_pkg::bus_data_t  psg_rdata;
	logic                 psg_rdata_en;
	cart_pkg::bus_data_t  tmr_rdata;
	logic                 tmr_rdata_en;
	cart_pkg::bus_data_t  period_a;
	cart_pkg::bus_data_t  period_b;
	cart_pkg::bus_data_t  period_c;
	logic [2:0]           tone_enable_n;
	logic [3:0]           volume_a;
	logic [3:0]           volume_b;
	logic [3:0]           volume_c;
	cart_pkg::mix_level_t mix_level;

	// --------------------------------------------------------------------
	// Bus pins and write strobe
	// --------------------------------------------------------------------
	assign bus.n_iorq  = n_tiorq;
	assign bus.n_rd    = n_trd;
	assign bus.n_wr    = n_twr;
	assign bus.address = ta;
	assign bus.wdata   = td_in;

	assign wr_cond = !bus.n_iorq && !bus.n_wr;

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			wr_cond_q <= 1'b0;
		end else begin
			wr_cond_q <= wr_cond;
		end
	end

	// First clk of the write only
	assign bus.wr_strobe = wr_cond && !wr_cond_q;

	// PSG data first when both would answer
	assign tdir   = psg_rdata_en | tmr_rdata_en;
	assign td_out = !tdir        ? 8'h00 :
	                psg_rdata_en ? psg_rdata : tmr_rdata;

	// --------------------------------------------------------------------
	// Peripherals
	// --------------------------------------------------------------------
	cart_timing u_timing (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.mclk_en   (mclk_en),
		.twait     (twait)
	);

	psg_regs u_psg_regs (
		.clk           (clk),
		.w_n_reset     (w_n_reset),
		.bus           (bus.peripheral),
		.rdata         (psg_rdata),
		.rdata_en      (psg_rdata_en),
		.period_a      (period_a),
		.period_b      (period_b),
		.period_c      (period_c),
		.tone_enable_n (tone_enable_n),
		.volume_a      (volume_a),
		.volume_b      (volume_b),
		.volume_c      (volume_c)
	);

	psg_tone u_psg_tone (
		.clk           (clk),
		.w_n_reset     (w_n_reset),
		.mclk_en       (mclk_en),
		.period_a      (period_a),
		.period_b      (period_b),
		.period_c      (period_c),
		.tone_enable_n (tone_enable_n),
		.volume_a      (volume_a),
		.volume_b      (volume_b),
		.volume_c      (volume_c),
		.mix_level     (mix_level)
	);

	cart_timer_irq u_timer (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.mclk_en   (mclk_en),
		.bus       (bus.peripheral),
		.rdata     (tmr_rdata),
		.rdata_en  (tmr_rdata_en),
		.tint      (tint)
	);

	sound_pwm u_pwm (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.mix_level (mix_level),
		.tsnd      (tsnd)
	);

endmodule

/* bench/tangcart_tb.sv */
// Testbench for the sound cartridge top level.
// Reads bench/cart_cases.txt, drives I/O cycles on the falling clk edge
// and checks read-back, PWM levels, tone frames and the timer interrupt.
// Extra PSG read-back cases come from an LCG with a fixed seed.

`timescale 1ns/1ps

module tangcart_tb;

	localparam logic [31:0] LCG_SEED = 32'h5bf7_b837;
	localparam int RANDOM_CASES = 8;

	logic                clk = 1'b0;
	logic                w_n_reset;
	logic                n_tiorq;
	logic                n_trd;
	logic                n_twr;
	cart_pkg::io_addr_t  ta;
	cart_pkg::bus_data_t td_in;
	cart_pkg::bus_data_t td_out;
	logic                tdir;
	logic                twait;
	logic                tint;
	logic                tsnd;

	// Case table loaded from the data file
	string               kinds [$];
	cart_pkg::bus_data_t field_a [$];
	cart_pkg::bus_data_t field_b [$];
	cart_pkg::bus_data_t field_c [$];

	int          cycle_cnt = 0;
	int          cycle_limit = 0;
	int          since_release = 0;
	logic [31:0] rand_state;

	tangcart_top dut (
		.clk       (clk),
		.w_n_reset (w_n_reset),
		.n_tiorq   (n_tiorq),
		.n_trd     (n_trd),
		.n_twr     (n_twr),
		.ta        (ta),
		.td_in     (td_in),
		.td_out    (td_out),
		.tdir      (tdir),
		.twait     (twait),
		.tint      (tint),
		.tsnd      (tsnd)
	);

	always #5 clk = ~clk;

	// --------------------------------------------------------------------
	// Watchdog and frame position
	// --------------------------------------------------------------------
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit != 0) begin
			assert (cycle_cnt < cycle_limit) else begin
				$display("Timeout: run went past %0d clk cycles", cycle_limit);
				stop_on_failure();
			end
		end
	end

	// Posedges since reset release, frames start at multiples of 256
	always @(posedge clk) begin
		if (!w_n_reset) begin
			since_release <= 0;
		end else begin
			since_release <= since_release + 1;
		end
	end

	task automatic stop_on_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_value(string name, int expected, int actual);
		assert (actual == expected) else begin
			$display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
			stop_on_failure();
		end
	endtask

	// LCG step with the Numerical Recipes constants
	function automatic logic [31:0] lcg_next(logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// PSG read-back by register index
	function automatic cart_pkg::bus_data_t expected_readback(logic [3:0] idx,
		cart_pkg::bus_data_t value);
		if (idx == cart_pkg::REG_PERIOD_A || idx == cart_pkg::REG_PERIOD_B ||
			idx == cart_pkg::REG_PERIOD_C || idx == cart_pkg::REG_ENABLE) begin
			return value;
		end
		if (idx == cart_pkg::REG_VOLUME_A || idx == cart_pkg::REG_VOLUME_B ||
			idx == cart_pkg::REG_VOLUME_C) begin
			return {4'h0, value[3:0]};
		end
		return 8'hFF;
	endfunction

	// Rough clk budget of one case, zero for an unknown kind
	function automatic int case_cycles(string kind, cart_pkg::bus_data_t a,
		cart_pkg::bus_data_t b);
		if (kind == "wr" || kind == "rd") begin
			return 10;
		end
		if (kind == "pwm") begin
			return 4 * cart_pkg::PWM_PERIOD;
		end
		if (kind == "tone") begin
			return (int'(b) + 4) * cart_pkg::PWM_PERIOD;
		end
		if (kind == "irq") begin
			return 3 * ((int'(a) + 2) * cart_pkg::MCLK_DIV + 2) + 40;
		end
		return 0;
	endfunction

	// --------------------------------------------------------------------
	// Bus cycles, strobes held for 3 clk
	// --------------------------------------------------------------------
	task automatic io_write(cart_pkg::io_addr_t port, cart_pkg::bus_data_t value);
		@(negedge clk);
		ta      = port;
		td_in   = value;
		n_tiorq = 1'b0;
		n_twr   = 1'b0;
		repeat (3) @(negedge clk);
		// No read data may be driven during a write
		check_value("write tdir", 0, int'(tdir));
		n_tiorq = 1'b1;
		n_twr   = 1'b1;
	endtask

	task automatic io_read(cart_pkg::io_addr_t port, output cart_pkg::bus_data_t data,
		output logic dir);
		@(negedge clk);
		ta      = port;
		n_tiorq = 1'b0;
		n_trd   = 1'b0;
		repeat (3) @(negedge clk);
		data    = td_out;
		dir     = tdir;
		n_tiorq = 1'b1;
		n_trd   = 1'b1;
	endtask

	// tsnd high count over the next whole PWM frame
	task automatic count_frame(output int cnt);
		cnt = 0;
		@(negedge clk);
		while (since_release % cart_pkg::PWM_PERIOD != 1) begin
			@(negedge clk);
		end
		for (int i = 0; i < cart_pkg::PWM_PERIOD; i++) begin
			if (i != 0) begin
				@(negedge clk);
			end
			if (tsnd) begin
				cnt++;
			end
		end
	endtask

	task automatic wait_for_tint(string name, int limit);
		int waited;
		waited = 0;
		while (!tint && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		assert (tint) else begin
			$display("%s: tint did not rise within %0d clk cycles", name, limit);
			stop_on_failure();
		end
	endtask

	// --------------------------------------------------------------------
	// Timer interrupt sequence
	// --------------------------------------------------------------------
	task automatic timer_case(string name, cart_pkg::bus_data_t reload,
		cart_pkg::bus_data_t irq_en, cart_pkg::bus_data_t exp_status);
		cart_pkg::bus_data_t data;
		logic                dir;
		int                  limit;
		limit = (int'(reload) + 2) * cart_pkg::MCLK_DIV + 2;
		// Stop and clear, then load and start
		io_write(cart_pkg::PORT_TIMER_CTRL, 8'h80);
		io_write(cart_pkg::PORT_TIMER_RELOAD, reload);
		io_write(cart_pkg::PORT_TIMER_CTRL, irq_en[0] ? 8'h03 : 8'h01);
		if (irq_en[0]) begin
			wait_for_tint(name, limit);
			io_read(cart_pkg::PORT_TIMER_CTRL, data, dir);
			check_value({name, " status"}, int'(exp_status), int'(data));
			// Flag clear with run and enable kept
			io_write(cart_pkg::PORT_TIMER_CTRL, 8'h83);
			check_value({name, " tint after clear"}, 0, int'(tint));
			io_read(cart_pkg::PORT_TIMER_CTRL, data, dir);
			check_value({name, " status after clear"}, 8'h02, int'(data));
			wait_for_tint({name, " repeat"}, limit);
		end else begin
			repeat (limit) begin
				@(negedge clk);
				check_value({name, " tint masked"}, 0, int'(tint));
			end
			io_read(cart_pkg::PORT_TIMER_CTRL, data, dir);
			check_value({name, " status"}, int'(exp_status), int'(data));
		end
		io_write(cart_pkg::PORT_TIMER_CTRL, 8'h80);
	endtask

	// --------------------------------------------------------------------
	// One case from the file
	// --------------------------------------------------------------------
	task automatic run_case(string name, string kind, cart_pkg::bus_data_t a,
		cart_pkg::bus_data_t b, cart_pkg::bus_data_t c);
		cart_pkg::bus_data_t data;
		cart_pkg::io_addr_t  port;
		logic                dir;
		int                  cnt;
		bit                  seen_zero;
		bit                  seen_level;
		seen_zero  = 1'b0;
		seen_level = 1'b0;
		port       = a;
		// Targets below 10h are PSG register indices
		if ((kind == "wr" || kind == "rd") && a < 8'h10) begin
			io_write(cart_pkg::PORT_PSG_ADDR, a);
			port = (kind == "wr") ? cart_pkg::PORT_PSG_WRITE : cart_pkg::PORT_PSG_READ;
		end
		if (kind == "wr") begin
			io_write(port, b);
		end else if (kind == "rd") begin
			io_read(port, data, dir);
			check_value({name, " tdir"}, int'(b[0]), int'(dir));
			if (b[0]) begin
				check_value(name, int'(c), int'(data));
			end
		end else if (kind == "pwm") begin
			// Two frames so the new level is latched
			repeat (2 * cart_pkg::PWM_PERIOD) @(negedge clk);
			count_frame(cnt);
			check_value(name, int'(c), cnt);
		end else if (kind == "tone") begin
			repeat (2 * cart_pkg::PWM_PERIOD) @(negedge clk);
			for (int f = 0; f < int'(b); f++) begin
				count_frame(cnt);
				assert (cnt == 0 || cnt == int'(c)) else begin
					$display("ERROR %s: expected 0 or %0h, actual %0h", name, c, cnt);
					stop_on_failure();
				end
				if (cnt == 0) begin
					seen_zero = 1'b1;
				end else begin
					seen_level = 1'b1;
				end
			end
			assert (seen_zero && seen_level) else begin
				$display("%s: tone frames did not show both silence and the level", name);
				stop_on_failure();
			end
		end else begin
			timer_case(name, a, b, c);
		end
	endtask

	task automatic load_cases();
		int                  fd;
		int                  n;
		string               line;
		string               kind;
		cart_pkg::bus_data_t a;
		cart_pkg::bus_data_t b;
		cart_pkg::bus_data_t c;
		fd = $fopen("bench/cart_cases.txt", "r");
		assert (fd != 0) else begin
			$display("Could not open the case file bench/cart_cases.txt");
			stop_on_failure();
		end
		while ($fgets(line, fd) > 0) begin
			// Skip blank and comment lines
			if (line.len() > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%s %h %h %h", kind, a, b, c);
				assert (n == 4 && case_cycles(kind, a, b) > 0) else begin
					$display("Malformed line in the case file: %s", line);
					stop_on_failure();
				end
				kinds.push_back(kind);
				field_a.push_back(a);
				field_b.push_back(b);
				field_c.push_back(c);
			end
		end
		$fclose(fd);
	endtask

	// --------------------------------------------------------------------
	// Main sequence
	// --------------------------------------------------------------------
	initial begin
		string               name;
		cart_pkg::bus_data_t data;
		cart_pkg::bus_data_t value;
		logic                dir;
		logic [3:0]          idx;
		int                  high_cycles;
		int                  total;
		w_n_reset = 1'b0;
		n_tiorq   = 1'b1;
		n_trd     = 1'b1;
		n_twr     = 1'b1;
		ta        = 8'h00;
		td_in     = 8'h00;
		load_cases();
		total = 40 + RANDOM_CASES * 20;
		for (int i = 0; i < kinds.size(); i++) begin
			total += case_cycles(kinds[i], field_a[i], field_b[i]);
		end
		cycle_limit = 20 * total;

		// Outputs idle while reset is held
		repeat (4) @(negedge clk);
		check_value("reset tdir", 0, int'(tdir));
		check_value("reset tint", 0, int'(tint));
		check_value("reset tsnd", 0, int'(tsnd));
		check_value("reset td_out", 0, int'(td_out));
		check_value("reset twait", 1, int'(twait));
		w_n_reset   = 1'b1;
		high_cycles = 0;
		while (twait && high_cycles < 4 * cart_pkg::STARTUP_WAIT_CYCLES) begin
			check_value("startup tdir", 0, int'(tdir));
			check_value("startup tint", 0, int'(tint));
			check_value("startup tsnd", 0, int'(tsnd));
			high_cycles++;
			@(negedge clk);
		end
		check_value("twait high cycles", cart_pkg::STARTUP_WAIT_CYCLES, high_cycles);

		for (int i = 0; i < kinds.size(); i++) begin
			name = $sformatf("case %0d %s", i + 1, kinds[i]);
			run_case(name, kinds[i], field_a[i], field_b[i], field_c[i]);
		end

		// Random PSG read-back
		rand_state = LCG_SEED;
		for (int i = 0; i < RANDOM_CASES; i++) begin
			rand_state = lcg_next(rand_state);
			idx        = rand_state[27:24];
			value      = rand_state[15:8];
			name       = $sformatf("random %0d reg %0h", i + 1, idx);
			io_write(cart_pkg::PORT_PSG_ADDR, {4'h0, idx});
			io_write(cart_pkg::PORT_PSG_WRITE, value);
			io_read(cart_pkg::PORT_PSG_READ, data, dir);
			check_value({name, " tdir"}, 1, int'(dir));
			check_value(name, int'(expected_readback(idx, value)), int'(data));
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* bench/cart_cases.txt */
# kind target value expected, all fields hex
# target below 10h is a PSG register index, else an I/O port
wr 00 5a 00
rd 00 01 5a
wr 07 3c 00
rd 07 01 3c
wr 09 f7 00
rd 09 01 07
wr 03 12 00
rd 03 01 ff
rd a3 00 00
rd a4 00 00
wr 00 00 00
wr 07 fc 00
wr 08 05 00
wr 09 0a 00
wr 0a 0f 00
pwm 00 00 3c
wr 07 f8 00
pwm 00 00 78
wr 07 fe 00
wr 00 64 00
tone 00 0c 14
irq 05 01 03
irq 04 00 03

/* sources.f */
verilog/cart_pkg.sv
verilog/cart_io_bus_if.sv
verilog/cart_timing.sv
verilog/psg_regs.sv
verilog/psg_tone.sv
verilog/cart_timer_irq.sv
verilog/sound_pwm.sv
verilog/tangcart_top.sv
bench/tangcart_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the cartridge testbench with Verilator, run it and check sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
	--top-module tangcart_tb -o tangcart_sim > sim.log 2>&1 &&
./obj_dir/tangcart_sim >> sim.log 2>&1 ||
echo "*** TEST FAILED ***" >> sim.log
cat sim.log
grep -q "\*\*\* TEST FAILED \*\*\*" sim.log && exit 1 || exit 0
